// File: rtl/lms_pkg.sv
`default_nettype none

package lms_pkg;

  localparam int NUM_TAPS = 7;
  localparam int SAMPLE_W = 16;
  localparam int COEFF_W  = 17;
  localparam int MU_W     = 16;
  localparam int ACC_W    = 36;

  // q1.15 samples, q2.15 weights, q1.15 step size.
  typedef logic signed [SAMPLE_W-1:0] sample_t;
  typedef logic signed [COEFF_W-1:0]  coeff_t;
  typedef logic signed [MU_W-1:0]     mu_t;
  typedef logic signed [ACC_W-1:0]    acc_t;

  // 1..7 selects taps 0..6, 0 selects nothing.
  typedef logic [2:0] tap_sel_t;

  typedef struct packed {
    logic     shift_en;
    logic     mac_clr;
    logic     mac_en;
    logic     err_en;
    logic     prod1_en;
    logic     prod2_en;
    tap_sel_t sel;
  } lms_ctrl_t;

  typedef struct packed {
    sample_t y;
    sample_t e;
  } lms_out_t;

  typedef enum logic [2:0] {
    IDLE,
    SHIFT,
    FILTER,
    ERROR,
    SCALE,
    UPDATE_MUL,
    UPDATE_WR
  } ctrl_state_t;

endpackage

`default_nettype wire

// File: rtl/lms_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module lms_ctrl
  import lms_pkg::*;
(
  input  logic      clk,
  input  logic      nrst,
  input  logic      sample_valid,
  output lms_ctrl_t ctrl,
  output logic      ready,
  output logic      out_valid
);

  ctrl_state_t state;
  ctrl_state_t state_nxt;
  tap_sel_t    cnt;
  tap_sel_t    cnt_nxt;
  logic        last_tap;

  assign last_tap = (cnt == tap_sel_t'(NUM_TAPS));

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      state <= IDLE;
      cnt   <= '0;
    end else begin
      state <= state_nxt;
      cnt   <= cnt_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    cnt_nxt   = cnt;
    case (state)
      IDLE: begin
        if (sample_valid) begin
          state_nxt = SHIFT;
        end
      end
      SHIFT: begin
        state_nxt = FILTER;
        cnt_nxt   = tap_sel_t'(1);
      end
      FILTER: begin
        if (last_tap) begin
          state_nxt = ERROR;
          cnt_nxt   = '0;
        end else begin
          cnt_nxt = cnt + 1'b1;
        end
      end
      ERROR: begin
        state_nxt = SCALE;
      end
      SCALE: begin
        state_nxt = UPDATE_MUL;
        cnt_nxt   = tap_sel_t'(1);
      end
      UPDATE_MUL: begin
        state_nxt = UPDATE_WR;
      end
      UPDATE_WR: begin
        // two cycles per tap, the write lands while sel still points at it.
        if (last_tap) begin
          state_nxt = IDLE;
          cnt_nxt   = '0;
        end else begin
          state_nxt = UPDATE_MUL;
          cnt_nxt   = cnt + 1'b1;
        end
      end
      default: begin
        state_nxt = IDLE;
        cnt_nxt   = '0;
      end
    endcase
  end

  always_comb begin
    ctrl.shift_en = (state == SHIFT);
    ctrl.mac_clr  = (state == SHIFT);
    ctrl.mac_en   = (state == FILTER);
    ctrl.err_en   = (state == ERROR);
    ctrl.prod1_en = (state == SCALE);
    ctrl.prod2_en = (state == UPDATE_MUL);
    // counter is zero outside the tap phases.
    ctrl.sel      = cnt;
  end

  assign ready     = (state == IDLE);
  assign out_valid = (state == SCALE);

endmodule

`default_nettype wire

// File: rtl/tap_delay_line.sv
`timescale 1ns/1ps
`default_nettype none

module tap_delay_line
  import lms_pkg::*;
(
  input  logic      clk,
  input  logic      nrst,
  input  lms_ctrl_t ctrl,
  input  sample_t   x_in,
  output sample_t   u
);

  sample_t taps [NUM_TAPS];

  // newest sample sits in tap 0.
  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      for (int i = 0; i < NUM_TAPS; i++) begin
        taps[i] <= '0;
      end
    end else if (ctrl.shift_en) begin
      taps[0] <= x_in;
      for (int i = 1; i < NUM_TAPS; i++) begin
        taps[i] <= taps[i-1];
      end
    end
  end

  always_comb begin
    if (ctrl.sel == '0) begin
      u = '0;
    end else begin
      u = taps[ctrl.sel - 1'b1];
    end
  end

endmodule

`default_nettype wire

// File: rtl/filter_error_unit.sv
`timescale 1ns/1ps
`default_nettype none

module filter_error_unit
  import lms_pkg::*;
(
  input  logic      clk,
  input  logic      nrst,
  input  lms_ctrl_t ctrl,
  input  sample_t   d_in,
  input  coeff_t    w,
  input  sample_t   u,
  output lms_out_t  result
);

  sample_t                d_reg;
  acc_t                   acc;
  acc_t                   acc_rnd;
  sample_t                y_sat;
  logic [SAMPLE_W:0]      diff;
  sample_t                e_sat;

  always_ff @(posedge clk) begin
    if (ctrl.shift_en) begin
      d_reg <= d_in;
    end
  end

  // q2.15 by q1.15 products sum into a q3.30 accumulator.
  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      acc <= '0;
    end else if (ctrl.mac_clr) begin
      acc <= '0;
    end else if (ctrl.mac_en) begin
      acc <= acc + w * u;
    end
  end

  always_comb begin
    // round half up, back to q1.15.
    acc_rnd = (acc + (acc_t'(1) <<< (SAMPLE_W - 2))) >>> (SAMPLE_W - 1);
    if (&acc_rnd[ACC_W-1:SAMPLE_W-1] || ~|acc_rnd[ACC_W-1:SAMPLE_W-1]) begin
      y_sat = acc_rnd[SAMPLE_W-1:0];
    end else if (acc_rnd[ACC_W-1]) begin
      y_sat = {1'b1, {(SAMPLE_W-1){1'b0}}};
    end else begin
      y_sat = {1'b0, {(SAMPLE_W-1){1'b1}}};
    end

    diff = {d_reg[SAMPLE_W-1], d_reg} - {y_sat[SAMPLE_W-1], y_sat};
    if (diff[SAMPLE_W] == diff[SAMPLE_W-1]) begin
      e_sat = diff[SAMPLE_W-1:0];
    end else if (diff[SAMPLE_W]) begin
      e_sat = {1'b1, {(SAMPLE_W-1){1'b0}}};
    end else begin
      e_sat = {1'b0, {(SAMPLE_W-1){1'b1}}};
    end
  end

  // held until the next sample reaches the error phase.
  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      result <= '0;
    end else if (ctrl.err_en) begin
      result.y <= y_sat;
      result.e <= e_sat;
    end
  end

endmodule

`default_nettype wire

// File: rtl/adaptation_block.sv
`timescale 1ns/1ps
`default_nettype none

module adaptation_block
  import lms_pkg::*;
(
  input  logic      clk,
  input  logic      nrst,
  input  lms_ctrl_t ctrl,
  input  mu_t       mu,
  input  sample_t   u,
  input  sample_t   e,
  output coeff_t    w_mux
);

  coeff_t                          w [NUM_TAPS];
  coeff_t                          w_mux_del;
  coeff_t                          w_new;
  logic                            w_load_en;

  logic signed [SAMPLE_W+MU_W-1:0] prod_e_mu;
  logic [SAMPLE_W+1:0]             prod_e_mu_round;
  sample_t                         prod_e_mu_conv;

  logic signed [2*SAMPLE_W-1:0]    prod_e_mu_u;
  logic [COEFF_W:0]                prod_e_mu_u_round;
  coeff_t                          prod_e_mu_u_conv;

  // load enable trails prod2_en by one cycle, sel is still on the same tap.
  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      w_load_en <= 1'b0;
    end else begin
      w_load_en <= ctrl.prod2_en;
    end
  end

  always_ff @(posedge clk) begin
    w_mux_del <= w_mux;
  end

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      for (int i = 0; i < NUM_TAPS; i++) begin
        w[i] <= '0;
      end
    end else if (w_load_en && ctrl.sel != '0) begin
      w[ctrl.sel - 1'b1] <= w_new;
    end
  end

  assign w_mux = (ctrl.sel == '0) ? '0 : w[ctrl.sel - 1'b1];

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      prod_e_mu   <= '0;
      prod_e_mu_u <= '0;
    end else begin
      if (ctrl.prod1_en) begin
        prod_e_mu <= e * mu;
      end
      if (ctrl.prod2_en) begin
        prod_e_mu_u <= u * prod_e_mu_conv;
      end
    end
  end

  // mu*e back to q1.15, clipped when the top two bits disagree.
  assign prod_e_mu_round = prod_e_mu[SAMPLE_W+MU_W-1 -: SAMPLE_W+2] + 1'b1;

  always_comb begin
    case (prod_e_mu_round[SAMPLE_W+1 -: 2])
      2'b10:   prod_e_mu_conv = {1'b1, {(SAMPLE_W-1){1'b0}}};
      2'b01:   prod_e_mu_conv = {1'b0, {(SAMPLE_W-1){1'b1}}};
      default: prod_e_mu_conv = prod_e_mu_round[SAMPLE_W:1];
    endcase
  end

  // q2.15 step, rounded half up, no saturation.
  assign prod_e_mu_u_round = prod_e_mu_u[2*SAMPLE_W-1 -: COEFF_W+1] + 1'b1;
  assign prod_e_mu_u_conv  = prod_e_mu_u_round[COEFF_W:1];

  assign w_new = w_mux_del + prod_e_mu_u_conv;

endmodule

`default_nettype wire

// File: rtl/lms_filter_top.sv
`timescale 1ns/1ps
`default_nettype none

module lms_filter_top
  import lms_pkg::*;
(
  input  logic     clk,
  input  logic     nrst,
  input  logic     sample_valid,
  input  sample_t  x_in,
  input  sample_t  d_in,
  input  mu_t      mu,
  output logic     ready,
  output logic     out_valid,
  output lms_out_t result
);

  lms_ctrl_t ctrl;
  sample_t   u;
  coeff_t    w_mux;

  lms_ctrl u_ctrl (
    .clk          (clk),
    .nrst         (nrst),
    .sample_valid (sample_valid),
    .ctrl         (ctrl),
    .ready        (ready),
    .out_valid    (out_valid)
  );

  tap_delay_line u_taps (
    .clk  (clk),
    .nrst (nrst),
    .ctrl (ctrl),
    .x_in (x_in),
    .u    (u)
  );

  filter_error_unit u_fe (
    .clk    (clk),
    .nrst   (nrst),
    .ctrl   (ctrl),
    .d_in   (d_in),
    .w      (w_mux),
    .u      (u),
    .result (result)
  );

  // error feeds back from the registered output.
  adaptation_block u_adapt (
    .clk   (clk),
    .nrst  (nrst),
    .ctrl  (ctrl),
    .mu    (mu),
    .u     (u),
    .e     (result.e),
    .w_mux (w_mux)
  );

endmodule

`default_nettype wire

// File: sim/lms_props.sv
`timescale 1ns/1ps
`default_nettype none

module lms_props (
  input logic clk,
  input logic nrst,
  input logic sample_valid,
  input logic ready,
  input logic out_valid
);

  logic accepted;

  assign accepted = sample_valid && ready;

  a_out_pulse: assert property (@(posedge clk) disable iff (!nrst)
    out_valid |=> !out_valid)
    else $error("out_valid held longer than one cycle");

  a_no_busy_sample: assert property (@(posedge clk) disable iff (!nrst)
    sample_valid |-> ready)
    else $error("sample_valid arrived while ready was low");

  a_ready_low: assert property (@(posedge clk) disable iff (!nrst)
    accepted |=> (!ready) [*24] ##1 ready)
    else $error("ready did not stay low for the sample period");

  a_out_latency: assert property (@(posedge clk) disable iff (!nrst)
    accepted |-> ##10 out_valid)
    else $error("out_valid not seen 10 cycles after the accepted sample");

endmodule

bind lms_filter_top lms_props u_props (
  .clk          (clk),
  .nrst         (nrst),
  .sample_valid (sample_valid),
  .ready        (ready),
  .out_valid    (out_valid)
);

`default_nettype wire

// File: sim/lms_checker.sv
`timescale 1ns/1ps
`default_nettype none

module lms_checker
  import lms_pkg::*;
(
  input  logic        clk,
  input  logic        nrst,
  input  logic        sample_valid,
  input  logic        ready,
  input  sample_t     x_in,
  input  sample_t     d_in,
  input  mu_t         mu,
  input  logic        out_valid,
  input  lms_out_t    result,
  input  logic [63:0] name,
  input  logic        hand_valid,
  input  sample_t     hand_y,
  input  sample_t     hand_e,
  input  logic        sysid,
  input  logic        finish,
  output int          errors,
  output int          checks
);

  sample_t     m_taps [NUM_TAPS];
  coeff_t      m_w [NUM_TAPS];
  sample_t     p_x;
  sample_t     p_d;
  logic [63:0] p_name;
  logic        p_hand;
  sample_t     p_hand_y;
  sample_t     p_hand_e;
  logic        p_sysid;
  int          sys_e [$];
  logic        fin_done;

  function automatic int clamp16(longint v);
    if (v > 32767) begin
      return 32767;
    end else if (v < -32768) begin
      return -32768;
    end
    return int'(v);
  endfunction

  task automatic run_sample();
    longint      acc;
    int          y_exp;
    int          e_exp;
    logic signed [31:0] p1;
    logic signed [31:0] p2;
    logic [17:0] r1;
    logic [17:0] r2;
    sample_t     conv;
    coeff_t      step;
    logic        bad;
    for (int k = NUM_TAPS - 1; k > 0; k--) begin
      m_taps[k] = m_taps[k-1];
    end
    m_taps[0] = p_x;
    acc = 0;
    for (int k = 0; k < NUM_TAPS; k++) begin
      acc += longint'(m_w[k]) * longint'(m_taps[k]);
    end
    y_exp = clamp16((acc + 16384) >>> 15);
    e_exp = clamp16(longint'(p_d) - longint'(y_exp));
    bad = (result.y != sample_t'(y_exp)) || (result.e != sample_t'(e_exp));
    if (p_hand) begin
      bad = bad || (result.y != p_hand_y) || (result.e != p_hand_e);
    end
    checks++;
    if (bad) begin
      errors++;
      $display("FAILED %0s: expected y=%0d e=%0d, actual y=%0d e=%0d",
               p_name, y_exp, e_exp, result.y, result.e);
    end else begin
      $display("PASS %0s: y=%0d e=%0d", p_name, y_exp, e_exp);
    end
    if (p_sysid) begin
      sys_e.push_back((e_exp < 0) ? -e_exp : e_exp);
    end
    // mu*e to q1.15 with clipping, then one step per tap.
    p1 = sample_t'(e_exp) * mu;
    r1 = p1[31:14] + 18'd1;
    if (r1[17:16] == 2'b10) begin
      conv = 16'sh8000;
    end else if (r1[17:16] == 2'b01) begin
      conv = 16'sh7fff;
    end else begin
      conv = r1[16:1];
    end
    for (int k = 0; k < NUM_TAPS; k++) begin
      p2 = m_taps[k] * conv;
      r2 = p2[31:14] + 18'd1;
      step = r2[17:1];
      m_w[k] = m_w[k] + step;
    end
  endtask

  // adaptation must shrink the error over the identification run.
  task automatic check_convergence();
    int first_sum;
    int last_sum;
    first_sum = 0;
    last_sum = 0;
    if (sys_e.size() < 40) begin
      errors++;
      $display("convergence: too few identification samples were seen");
    end else begin
      for (int i = 0; i < 20; i++) begin
        first_sum += sys_e[i];
        last_sum += sys_e[sys_e.size() - 20 + i];
      end
      checks++;
      if (last_sum >= first_sum) begin
        errors++;
        $display("convergence: mean |e| of the last 20 samples is not below the first 20");
      end else begin
        $display("PASS convergence: sum |e| first=%0d last=%0d", first_sum, last_sum);
      end
    end
  endtask

  always @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      for (int k = 0; k < NUM_TAPS; k++) begin
        m_taps[k] = '0;
        m_w[k] = '0;
      end
    end else begin
      if (sample_valid && ready) begin
        p_x = x_in;
        p_d = d_in;
        p_name = name;
        p_hand = hand_valid;
        p_hand_y = hand_y;
        p_hand_e = hand_e;
        p_sysid = sysid;
      end
      if (out_valid) begin
        run_sample();
      end
      if (finish && !fin_done) begin
        fin_done = 1'b1;
        check_convergence();
      end
    end
  end

  initial begin
    errors = 0;
    checks = 0;
    fin_done = 1'b0;
  end

endmodule

`default_nettype wire

// File: sim/lms_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lms_tb
  import lms_pkg::*;
();

  localparam int M_HAND  = 0;
  localparam int M_MU0   = 1;
  localparam int M_RAND  = 2;
  localparam int M_FIX   = 3;
  localparam int M_SYSID = 4;
  localparam int NROWS   = 6;

  typedef struct {
    logic [63:0] name;
    int          count;
    int          mode;
    sample_t     x;
    sample_t     d;
    mu_t         mu;
    bit          rst;
  } row_t;

  logic        clk;
  logic        nrst;
  logic        sample_valid;
  sample_t     x_in;
  sample_t     d_in;
  mu_t         mu;
  logic        ready;
  logic        out_valid;
  lms_out_t    result;
  logic [63:0] name;
  logic        hand_valid;
  sample_t     hand_y;
  sample_t     hand_e;
  logic        sysid;
  logic        finish;
  int          errors;
  int          checks;
  int          timing_errs;
  int          limit;
  int          cycles;
  logic [15:0] lfsr;
  row_t        rows [NROWS];

  lms_filter_top u_lms_filter_top (.*);

  lms_checker u_checker (.*);

  // x^16 + x^14 + x^13 + x^11 + 1.
  function automatic logic [15:0] take_bits(int n);
    logic [15:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v = {v[14:0], fb};
    end
    return v;
  endfunction

  task automatic apply_reset();
    @(negedge clk);
    nrst = 1'b0;
    repeat (3) @(negedge clk);
    nrst = 1'b1;
  endtask

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles > limit) begin
        $display("timeout: DUT stopped producing outputs");
        $display("CHECKS FAILED");
        $finish;
      end
    end
  end

  initial begin
    sample_t x_h1;
    sample_t x_h2;
    int      cyc;
    int      ov_at;
    int      ov_cnt;
    int      total;
    rows[0] = '{"first", 1, M_HAND, 16'sh1000, 16'sh0800, 16'sh0000, 1'b0};
    rows[1] = '{"mu_zero", 6, M_MU0, 0, 0, 16'sh0000, 1'b0};
    rows[2] = '{"random", 40, M_RAND, 0, 0, 0, 1'b0};
    rows[3] = '{"sat_mu", 4, M_FIX, 16'sh7fff, -16'sh8000, -16'sh8000, 1'b1};
    rows[4] = '{"sat_pos", 3, M_FIX, 16'sh7fff, 16'sh7fff, 16'sh7fff, 1'b0};
    rows[5] = '{"sysid", 60, M_SYSID, 0, 0, 16'sh2000, 1'b1};
    lfsr = 16'd37481;
    nrst = 1'b0;
    sample_valid = 1'b0;
    x_in = '0;
    d_in = '0;
    mu = '0;
    name = '0;
    hand_valid = 1'b0;
    hand_y = '0;
    hand_e = '0;
    sysid = 1'b0;
    finish = 1'b0;
    timing_errs = 0;
    x_h1 = '0;
    x_h2 = '0;
    total = 0;
    for (int r = 0; r < NROWS; r++) begin
      total += rows[r].count;
    end
    limit = total * 25 + 50;
    repeat (3) @(negedge clk);
    nrst = 1'b1;
    if (!ready || out_valid) begin
      timing_errs++;
      $display("after reset ready is not high or out_valid is not low");
    end
    for (int r = 0; r < NROWS; r++) begin
      if (rows[r].rst) begin
        apply_reset();
        x_h1 = '0;
        x_h2 = '0;
      end
      for (int s = 0; s < rows[r].count; s++) begin
        while (!ready) @(negedge clk);
        name = rows[r].name;
        mu = rows[r].mu;
        sysid = (rows[r].mode == M_SYSID);
        case (rows[r].mode)
          M_MU0, M_RAND: begin
            x_in = take_bits(16);
            d_in = take_bits(16);
            if (rows[r].mode == M_RAND) begin
              mu = take_bits(14);
            end
          end
          M_SYSID: begin
            x_in = sample_t'(take_bits(16)) >>> 1;
            d_in = x_h2 >>> 1;
          end
          default: begin
            x_in = rows[r].x;
            d_in = rows[r].d;
          end
        endcase
        x_h2 = x_h1;
        x_h1 = x_in;
        // with all weights at zero the output is zero and the error is d.
        hand_valid = (rows[r].mode == M_HAND) || (rows[r].mode == M_MU0);
        hand_y = '0;
        hand_e = d_in;
        sample_valid = 1'b1;
        @(negedge clk);
        sample_valid = 1'b0;
        cyc = 1;
        ov_at = 0;
        ov_cnt = 0;
        while (cyc < 25) begin
          if (out_valid) begin
            ov_at = cyc;
            ov_cnt++;
          end
          if (ready) begin
            timing_errs++;
            $display("ready rose %0d cycles after an accepted sample", cyc);
          end
          @(negedge clk);
          cyc++;
        end
        if (!ready || ov_cnt != 1 || ov_at != 10) begin
          timing_errs++;
          $display("sample timing wrong: %0d out_valid cycles, last at %0d, ready %0b at 25",
                   ov_cnt, ov_at, ready);
        end
      end
    end
    finish = 1'b1;
    @(posedge clk);
    @(negedge clk);
    $display("checks: %0d, errors: %0d, timing errors: %0d", checks, errors, timing_errs);
    if (errors == 0 && timing_errs == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
rtl/lms_pkg.sv
rtl/lms_ctrl.sv
rtl/tap_delay_line.sv
rtl/filter_error_unit.sv
rtl/adaptation_block.sv
rtl/lms_filter_top.sv
sim/lms_props.sv
sim/lms_checker.sv
sim/lms_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= lms_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= ALL CHECKS PASSED

SOURCES := $(shell cat $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	@out=$$(./$(BIN)); echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
